/* icache_cfg_pkg.sv */
/*
 * Cache geometry for the direct-mapped instruction cache, the fetch address
 * union with raw and field views, and the cache line data type
 */
`default_nettype none

package icache_cfg_pkg;

    // Fetch and bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // Cache geometry
    localparam int LINE_WORDS = 4;
    localparam int LINE_COUNT = 16;

    // Derived address field widths
    localparam int BYTE_OFS_W = $clog2(DATA_W / 8);
    localparam int WORD_OFS_W = $clog2(LINE_WORDS);
    localparam int INDEX_W    = $clog2(LINE_COUNT);
    localparam int TAG_W      = ADDR_W - INDEX_W - WORD_OFS_W - BYTE_OFS_W;

    // One cache line, word 0 in the low bits
    typedef logic [LINE_WORDS-1:0][DATA_W-1:0] line_data_t;

    // Field view of a fetch address, most significant field first
    typedef struct packed {
        logic [TAG_W-1:0]      tag;
        logic [INDEX_W-1:0]    index;
        logic [WORD_OFS_W-1:0] word;
        logic [BYTE_OFS_W-1:0] byte_ofs;
    } fetch_addr_fields_t;

    // The same address word, seen either as a plain bus address or split into
    // the fields used for indexing and tag compare
    typedef union packed {
        logic [ADDR_W-1:0]  raw;
        fetch_addr_fields_t fields;
    } fetch_addr_u;

endpackage

`default_nettype wire

/* icache_bus_pkg.sv */
/*
 * Wishbone classic master and slave signal bundles, and the request and
 * response bundles between the cache front ends and the refill unit
 */
`default_nettype none

package icache_bus_pkg;

    import icache_cfg_pkg::*;

    // Master to slave; the cache only ever reads, so we stays low
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [ADDR_W-1:0]   adr;
        logic [DATA_W/8-1:0] sel;
    } wb_m2s_t;

    // Slave to master
    typedef struct packed {
        logic [DATA_W-1:0] dat;
        logic              ack;
        logic              err;
    } wb_s2m_t;

    // Line-aligned address for a refill, word address for a bypass read
    typedef struct packed {
        fetch_addr_u addr;
    } refill_req_t;

    // Returned line; error is set if any beat answered with err
    typedef struct packed {
        line_data_t line;
        logic       error;
    } refill_rsp_t;

endpackage

`default_nettype wire

/* icache_lookup.sv */
/*
 * Direct-mapped lookup stage with flop-based tag, valid and data arrays,
 * hit check, line miss requests, line install and the flush handshake
 */
`default_nettype none

module icache_lookup
    import icache_cfg_pkg::*;
    import icache_bus_pkg::*;
(
    input  wire logic              clk_i,
    input  wire logic              reset_i,

    input  wire fetch_addr_u       fetch_addr_i,
    input  wire logic              fetch_valid_i,
    output logic                   fetch_ready_o,
    output logic [DATA_W-1:0]      fetch_data_o,
    output logic                   fetch_error_o,

    input  wire logic              flush_valid_i,
    output logic                   flush_ready_o,

    output refill_req_t            refill_req_o,
    output logic                   refill_req_valid_o,
    input  wire logic              refill_req_ready_i,
    input  wire refill_rsp_t       refill_rsp_i,
    input  wire logic              refill_rsp_valid_i
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_REQ,
        S_WAIT,
        S_DONE,
        S_FLUSH
    } state_e;

    state_e                  state_q;
    logic [LINE_COUNT-1:0]   valid_q;
    logic [TAG_W-1:0]        tag_q [LINE_COUNT];
    line_data_t              data_q [LINE_COUNT];

    fetch_addr_u             req_q;
    fetch_addr_u             line_addr;
    logic [DATA_W-1:0]       word_q;
    logic                    err_q;

    logic [INDEX_W-1:0]      idx;
    logic                    hit;
    logic                    start_fetch;
    logic                    start_flush;
    logic                    install;

    assign idx = fetch_addr_i.fields.index;
    assign hit = valid_q[idx] && (tag_q[idx] == fetch_addr_i.fields.tag);

    // A new fetch may also start in the flush ready cycle, since the arrays
    // are already clear by then
    assign start_fetch = ((state_q == S_IDLE) || (state_q == S_FLUSH)) && fetch_valid_i;
    assign start_flush = (state_q == S_IDLE) && !fetch_valid_i && flush_valid_i;
    assign install     = (state_q == S_WAIT) && refill_rsp_valid_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= S_IDLE;
            valid_q <= '0;
        end else begin
            case (state_q)
                S_IDLE, S_FLUSH: begin
                    if (start_fetch) begin
                        state_q <= hit ? S_DONE : S_REQ;
                    end else if (start_flush) begin
                        state_q <= S_FLUSH;
                        valid_q <= '0;
                    end else begin
                        state_q <= S_IDLE;
                    end
                end
                S_REQ: begin
                    if (refill_req_ready_i) begin
                        state_q <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (refill_rsp_valid_i) begin
                        state_q <= S_DONE;
                        // A line that came back with a bus error is never kept
                        if (!refill_rsp_i.error) begin
                            valid_q[req_q.fields.index] <= 1'b1;
                        end
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_fetch) begin
            req_q  <= fetch_addr_i;
            word_q <= data_q[idx][fetch_addr_i.fields.word];
            err_q  <= 1'b0;
        end
        if (install) begin
            word_q <= refill_rsp_i.line[req_q.fields.word];
            err_q  <= refill_rsp_i.error;
            if (!refill_rsp_i.error) begin
                tag_q[req_q.fields.index]  <= req_q.fields.tag;
                data_q[req_q.fields.index] <= refill_rsp_i.line;
            end
        end
    end

    // Miss requests always ask for the whole aligned line
    always_comb begin
        line_addr                 = req_q;
        line_addr.fields.word     = '0;
        line_addr.fields.byte_ofs = '0;
    end

    assign refill_req_o.addr  = line_addr;
    assign refill_req_valid_o = (state_q == S_REQ);

    assign fetch_ready_o = (state_q == S_DONE);
    assign fetch_data_o  = word_q;
    assign fetch_error_o = err_q;
    assign flush_ready_o = (state_q == S_FLUSH);

endmodule

`default_nettype wire

/* icache_bypass.sv */
/*
 * Uncached fetch path that reads a single word through the refill unit
 * and presents it for one cycle
 */
`default_nettype none

module icache_bypass
    import icache_cfg_pkg::*;
    import icache_bus_pkg::*;
(
    input  wire logic         clk_i,
    input  wire logic         reset_i,

    input  wire fetch_addr_u  fetch_addr_i,
    input  wire logic         fetch_valid_i,
    output logic              fetch_ready_o,
    output logic [DATA_W-1:0] fetch_data_o,
    output logic              fetch_error_o,

    output refill_req_t       refill_req_o,
    output logic              refill_req_valid_o,
    input  wire logic         refill_req_ready_i,
    input  wire refill_rsp_t  refill_rsp_i,
    input  wire logic         refill_rsp_valid_i
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_WAIT,
        S_PRESENT
    } state_e;

    state_e            state_q;
    fetch_addr_u       word_addr_q;
    logic [DATA_W-1:0] data_q;
    logic              err_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= S_IDLE;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (fetch_valid_i) begin
                        state_q <= S_REQ;
                    end
                end
                S_REQ: begin
                    if (refill_req_ready_i) begin
                        state_q <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (refill_rsp_valid_i) begin
                        state_q <= S_PRESENT;
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == S_IDLE) && fetch_valid_i) begin
            word_addr_q                 <= fetch_addr_i;
            word_addr_q.fields.byte_ofs <= '0;
        end
        // The single beat of a bypass read lands in word 0 of the line
        if ((state_q == S_WAIT) && refill_rsp_valid_i) begin
            data_q <= refill_rsp_i.line[0];
            err_q  <= refill_rsp_i.error;
        end
    end

    assign refill_req_o.addr  = word_addr_q;
    assign refill_req_valid_o = (state_q == S_REQ);

    assign fetch_ready_o = (state_q == S_PRESENT);
    assign fetch_data_o  = data_q;
    assign fetch_error_o = err_q;

endmodule

`default_nettype wire

/* icache_refill.sv */
/*
 * Refill unit with a round-robin grant between line and word requests and
 * a Wishbone classic read master that collects beats into a line
 */
`default_nettype none

module icache_refill
    import icache_cfg_pkg::*;
    import icache_bus_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        reset_i,

    input  wire refill_req_t line_req_i,
    input  wire logic        line_req_valid_i,
    output logic             line_req_ready_o,
    output logic             line_rsp_valid_o,

    input  wire refill_req_t word_req_i,
    input  wire logic        word_req_valid_i,
    output logic             word_req_ready_o,
    output logic             word_rsp_valid_o,

    output refill_rsp_t      rsp_o,

    output wb_m2s_t          wb_o,
    input  wire wb_s2m_t     wb_i
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_BUS,
        S_RESP
    } state_e;

    state_e                state_q;
    // Owner of the current or most recent transaction
    // It doubles as the round-robin pointer
    logic                  owner_word_q;
    logic [WORD_OFS_W-1:0] beat_q;

    fetch_addr_u           base_q;
    fetch_addr_u           beat_addr;
    line_data_t            line_q;
    logic                  err_q;

    logic                  grant_line;
    logic                  grant_word;
    logic                  beat_done;
    logic                  last_beat;

    always_comb begin
        grant_line = 1'b0;
        grant_word = 1'b0;
        if (state_q != S_BUS) begin
            if (line_req_valid_i && word_req_valid_i) begin
                grant_line = owner_word_q;
                grant_word = !owner_word_q;
            end else begin
                grant_line = line_req_valid_i;
                grant_word = word_req_valid_i;
            end
        end
    end

    assign beat_done = (state_q == S_BUS) && (wb_i.ack || wb_i.err);
    // A word read is one beat, a line is LINE_WORDS beats
    assign last_beat = owner_word_q || (beat_q == WORD_OFS_W'(LINE_WORDS - 1));

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q      <= S_IDLE;
            owner_word_q <= 1'b0;
            beat_q       <= '0;
        end else begin
            if (grant_line || grant_word) begin
                state_q      <= S_BUS;
                owner_word_q <= grant_word;
                beat_q       <= '0;
            end else if (beat_done) begin
                beat_q <= beat_q + 1'b1;
                if (last_beat) begin
                    state_q <= S_RESP;
                end
            end else if (state_q == S_RESP) begin
                state_q <= S_IDLE;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (grant_line) begin
            base_q <= line_req_i.addr;
        end else if (grant_word) begin
            base_q <= word_req_i.addr;
        end
        if (grant_line || grant_word) begin
            err_q <= 1'b0;
        end else if (beat_done) begin
            // Errored beats are still stored so the line keeps its shape
            line_q[beat_q] <= wb_i.dat;
            err_q          <= err_q | wb_i.err;
        end
    end

    always_comb begin
        beat_addr             = base_q;
        beat_addr.fields.word = base_q.fields.word + beat_q;
    end

    always_comb begin
        wb_o.cyc = (state_q == S_BUS);
        wb_o.stb = (state_q == S_BUS);
        wb_o.we  = 1'b0;
        wb_o.adr = beat_addr.raw;
        wb_o.sel = '1;
    end

    assign line_req_ready_o = grant_line;
    assign word_req_ready_o = grant_word;

    assign rsp_o.line       = line_q;
    assign rsp_o.error      = err_q;
    assign line_rsp_valid_o = (state_q == S_RESP) && !owner_word_q;
    assign word_rsp_valid_o = (state_q == S_RESP) && owner_word_q;

endmodule

`default_nettype wire

/* icache_top.sv */
/*
 * Instruction cache top level: steers each fetch to the cached lookup or
 * the bypass path and joins both to the Wishbone refill unit
 */
`default_nettype none

module icache_top
    import icache_cfg_pkg::*;
    import icache_bus_pkg::*;
(
    input  wire logic         clk_i,
    input  wire logic         reset_i,

    input  wire fetch_addr_u  inst_addr_i,
    input  wire logic         inst_cacheable_i,
    input  wire logic         inst_valid_i,
    output logic              inst_ready_o,
    output logic [DATA_W-1:0] inst_data_o,
    output logic              inst_error_o,

    input  wire logic         flush_valid_i,
    output logic              flush_ready_o,

    output wb_m2s_t           wb_o,
    input  wire wb_s2m_t      wb_i
);

    logic              lookup_valid;
    logic              lookup_ready;
    logic [DATA_W-1:0] lookup_data;
    logic              lookup_error;

    logic              bypass_valid;
    logic              bypass_ready;
    logic [DATA_W-1:0] bypass_data;
    logic              bypass_error;

    refill_req_t       line_req;
    logic              line_req_valid;
    logic              line_req_ready;
    logic              line_rsp_valid;

    refill_req_t       word_req;
    logic              word_req_valid;
    logic              word_req_ready;
    logic              word_rsp_valid;

    refill_rsp_t       refill_rsp;

    // The cacheable bit is held with the fetch, so it also selects the result
    assign lookup_valid = inst_valid_i && inst_cacheable_i;
    assign bypass_valid = inst_valid_i && !inst_cacheable_i;

    assign inst_ready_o = inst_cacheable_i ? lookup_ready : bypass_ready;
    assign inst_data_o  = inst_cacheable_i ? lookup_data  : bypass_data;
    assign inst_error_o = inst_cacheable_i ? lookup_error : bypass_error;

    icache_lookup lookup_i (
        .clk_i              (clk_i),
        .reset_i            (reset_i),
        .fetch_addr_i       (inst_addr_i),
        .fetch_valid_i      (lookup_valid),
        .fetch_ready_o      (lookup_ready),
        .fetch_data_o       (lookup_data),
        .fetch_error_o      (lookup_error),
        .flush_valid_i      (flush_valid_i),
        .flush_ready_o      (flush_ready_o),
        .refill_req_o       (line_req),
        .refill_req_valid_o (line_req_valid),
        .refill_req_ready_i (line_req_ready),
        .refill_rsp_i       (refill_rsp),
        .refill_rsp_valid_i (line_rsp_valid)
    );

    icache_bypass bypass_i (
        .clk_i              (clk_i),
        .reset_i            (reset_i),
        .fetch_addr_i       (inst_addr_i),
        .fetch_valid_i      (bypass_valid),
        .fetch_ready_o      (bypass_ready),
        .fetch_data_o       (bypass_data),
        .fetch_error_o      (bypass_error),
        .refill_req_o       (word_req),
        .refill_req_valid_o (word_req_valid),
        .refill_req_ready_i (word_req_ready),
        .refill_rsp_i       (refill_rsp),
        .refill_rsp_valid_i (word_rsp_valid)
    );

    icache_refill refill_i (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .line_req_i       (line_req),
        .line_req_valid_i (line_req_valid),
        .line_req_ready_o (line_req_ready),
        .line_rsp_valid_o (line_rsp_valid),
        .word_req_i       (word_req),
        .word_req_valid_i (word_req_valid),
        .word_req_ready_o (word_req_ready),
        .word_rsp_valid_o (word_rsp_valid),
        .rsp_o            (refill_rsp),
        .wb_o             (wb_o),
        .wb_i             (wb_i)
    );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
/*
 * Testbench clock and synchronous reset generator
 */
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // Reset is released on a rising edge like any other driven input
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

`default_nettype wire

/* tb_icache_mem.sv */
/*
 * Wishbone classic slave memory model: data is the address XOR a pattern,
 * addresses with bit 31 set answer with err, and each beat has 0 to 3
 * random wait states
 */
`default_nettype none

module tb_icache_mem
    import icache_cfg_pkg::*;
    import icache_bus_pkg::*;
#(
    parameter logic [DATA_W-1:0] PATTERN = '0,
    parameter logic [31:0]       SEED    = 32'h1
) (
    input  wire logic    clk_i,
    input  wire logic    reset_i,
    input  wire wb_m2s_t wb_i,
    output wb_s2m_t      wb_o
);

    logic [31:0] rand_q;
    logic [31:0] rand_next;
    logic        busy_q;
    logic [1:0]  wait_q;
    logic        beat_seen;

    function automatic logic [31:0] next_rand(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    assign rand_next = next_rand(rand_q);

    // A beat that is not being answered in this cycle
    assign beat_seen = wb_i.cyc && wb_i.stb && !wb_o.ack && !wb_o.err;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rand_q <= SEED;
            busy_q <= 1'b0;
            wait_q <= '0;
            wb_o   <= '0;
        end else begin
            wb_o.ack <= 1'b0;
            wb_o.err <= 1'b0;
            if (beat_seen && !busy_q) begin
                rand_q <= rand_next;
            end
            if (beat_seen) begin
                if (!busy_q && (rand_next[17:16] != 2'd0)) begin
                    busy_q <= 1'b1;
                    wait_q <= rand_next[17:16];
                end else if (busy_q && (wait_q != 2'd1)) begin
                    wait_q <= wait_q - 2'd1;
                end else begin
                    busy_q   <= 1'b0;
                    wb_o.ack <= !wb_i.adr[ADDR_W-1];
                    wb_o.err <= wb_i.adr[ADDR_W-1];
                    wb_o.dat <= wb_i.adr ^ PATTERN;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb_icache.sv */
/*
 * Testbench for the instruction cache: directed and random fetches, a
 * valid/tag reference table, and assertions on every ready and bus beat
 */
`default_nettype none

module tb_icache
    import icache_cfg_pkg::*;
    import icache_bus_pkg::*;
();

    localparam int          CLK_PERIOD     = 8;
    localparam int          RESET_CYCLES   = 16;
    localparam logic [31:0] MEM_PATTERN    = 32'h5a3c_96e1;
    localparam logic [31:0] ERROR_BASE     = 32'h8000_0000;
    localparam logic [31:0] SEED           = 32'hf65d_73b7;
    localparam int          RESET_TIMEOUT  = 100;
    localparam int          FETCH_TIMEOUT  = 200;
    localparam int          FLUSH_TIMEOUT  = 20;
    localparam int          RANDOM_FETCHES = 300;

    logic              clk;
    logic              reset;
    fetch_addr_u       inst_addr;
    logic              inst_cacheable;
    logic              inst_valid;
    logic              inst_ready;
    logic [DATA_W-1:0] inst_data;
    logic              inst_error;
    logic              flush_valid;
    logic              flush_ready;
    wb_m2s_t           wb_m2s;
    wb_s2m_t           wb_s2m;

    // Reference valid/tag table
    logic              model_valid [LINE_COUNT];
    logic [TAG_W-1:0]  model_tag [LINE_COUNT];

    // Expected results of the fetch in flight
    logic [DATA_W-1:0] exp_data;
    logic              exp_error;
    logic [ADDR_W-1:0] exp_base;
    logic              bus_allowed;

    logic              beat_done;
    logic              cyc_q;
    int unsigned       beat_index;
    int unsigned       beat_total;
    int unsigned       cyc_total;

    tb_clock_gen #(
        .PERIOD       (CLK_PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) clock_gen_i (
        .clk_o   (clk),
        .reset_o (reset)
    );

    icache_top dut_i (
        .clk_i            (clk),
        .reset_i          (reset),
        .inst_addr_i      (inst_addr),
        .inst_cacheable_i (inst_cacheable),
        .inst_valid_i     (inst_valid),
        .inst_ready_o     (inst_ready),
        .inst_data_o      (inst_data),
        .inst_error_o     (inst_error),
        .flush_valid_i    (flush_valid),
        .flush_ready_o    (flush_ready),
        .wb_o             (wb_m2s),
        .wb_i             (wb_s2m)
    );

    tb_icache_mem #(
        .PATTERN (MEM_PATTERN),
        .SEED    (SEED)
    ) mem_i (
        .clk_i   (clk),
        .reset_i (reset),
        .wb_i    (wb_m2s),
        .wb_o    (wb_s2m)
    );

    function automatic logic [31:0] next_rand(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        $display("** Error at %0t: %s is %h, expected %h", $time, name, got, expected);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_failure(input string what);
        $display("At %0t: %s", $time, what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // Bus monitor; beat_index counts beats inside the current cyc
    assign beat_done = wb_m2s.cyc && wb_m2s.stb && (wb_s2m.ack || wb_s2m.err);

    always_ff @(posedge clk) begin
        if (reset) begin
            cyc_q      <= 1'b0;
            beat_index <= 0;
            beat_total <= 0;
            cyc_total  <= 0;
        end else begin
            cyc_q <= wb_m2s.cyc;
            if (wb_m2s.cyc && !cyc_q) begin
                cyc_total <= cyc_total + 1;
            end
            if (!wb_m2s.cyc) begin
                beat_index <= 0;
            end else if (beat_done) begin
                beat_index <= beat_index + 1;
            end
            if (beat_done) begin
                beat_total <= beat_total + 1;
            end
        end
    end

    ready_has_fetch: assert property (@(posedge clk) disable iff (reset)
        inst_ready |-> inst_valid)
        else report_failure("inst_ready_o was high with no fetch open");

    ready_data: assert property (@(posedge clk) disable iff (reset)
        inst_ready && !exp_error |-> inst_data == exp_data)
        else report_mismatch("inst_data_o", $sampled(inst_data), $sampled(exp_data));

    ready_error: assert property (@(posedge clk) disable iff (reset)
        inst_ready |-> inst_error == exp_error)
        else report_mismatch("inst_error_o", 32'($sampled(inst_error)),
                             32'($sampled(exp_error)));

    flush_has_request: assert property (@(posedge clk) disable iff (reset)
        flush_ready |-> flush_valid)
        else report_failure("flush_ready_o was high with no flush requested");

    beat_allowed: assert property (@(posedge clk) disable iff (reset)
        beat_done |-> bus_allowed)
        else report_failure("Bus beat while the reference table predicts a hit or no fetch");

    beat_address: assert property (@(posedge clk) disable iff (reset)
        beat_done |-> wb_m2s.adr == exp_base + beat_index * 4)
        else report_mismatch("wb_m2s.adr", $sampled(wb_m2s.adr),
                             $sampled(exp_base + beat_index * 4));

    read_only: assert property (@(posedge clk) disable iff (reset)
        wb_m2s.stb |-> wb_m2s.cyc && !wb_m2s.we && wb_m2s.sel == '1)
        else report_failure("Bus cycle is not a full-word read with stb inside cyc");

    task automatic clear_model();
        for (int i = 0; i < LINE_COUNT; i++) begin
            model_valid[i] = 1'b0;
            model_tag[i]   = '0;
        end
    endtask

    // One fetch through the handshake; checks beat count, cyc count and hit latency
    task automatic run_fetch(input logic [ADDR_W-1:0] addr, input logic cacheable);
        fetch_addr_u a;
        fetch_addr_u base;
        logic        hit;
        logic        err_expected;
        int          cycles;
        int unsigned beats_before;
        int unsigned cycs_before;
        int unsigned exp_beats;
        int unsigned exp_cycs;
        a.raw        = addr;
        hit          = cacheable && model_valid[a.fields.index]
                       && (model_tag[a.fields.index] == a.fields.tag);
        err_expected = (addr & ERROR_BASE) != '0;
        exp_beats    = hit ? 0 : (cacheable ? LINE_WORDS : 1);
        exp_cycs     = hit ? 0 : 1;
        base         = a;
        base.fields.byte_ofs = '0;
        if (cacheable) begin
            base.fields.word = '0;
        end
        @(posedge clk);
        beats_before = beat_total;
        cycs_before  = cyc_total;
        exp_data       <= {a.raw[ADDR_W-1:BYTE_OFS_W], BYTE_OFS_W'(0)} ^ MEM_PATTERN;
        exp_error      <= err_expected;
        exp_base       <= base.raw;
        bus_allowed    <= !hit;
        inst_addr      <= a;
        inst_cacheable <= cacheable;
        inst_valid     <= 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > FETCH_TIMEOUT) begin
                report_failure($sformatf("Timeout waiting for inst_ready_o at address %h", addr));
            end
        end while (!inst_ready);
        inst_valid  <= 1'b0;
        bus_allowed <= 1'b0;
        assert (beat_total - beats_before == exp_beats)
            else report_failure($sformatf("Fetch of %h made %0d bus beats instead of %0d",
                                          addr, beat_total - beats_before, exp_beats));
        assert (cyc_total - cycs_before == exp_cycs)
            else report_failure($sformatf("Fetch of %h opened %0d bus cycles instead of %0d",
                                          addr, cyc_total - cycs_before, exp_cycs));
        if (hit) begin
            assert (cycles == 2)
                else report_failure($sformatf("Hit at %h did not answer in one cycle", addr));
        end
        if (cacheable && !hit && !err_expected) begin
            model_valid[a.fields.index] = 1'b1;
            model_tag[a.fields.index]   = a.fields.tag;
        end
    endtask

    task automatic flush_cache();
        int cycles;
        @(posedge clk);
        flush_valid <= 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > FLUSH_TIMEOUT) begin
                report_failure("Timeout waiting for flush_ready_o");
            end
        end while (!flush_ready);
        flush_valid <= 1'b0;
        clear_model();
    endtask

    initial begin
        fetch_addr_u a;
        fetch_addr_u b;
        logic [31:0] rnd;
        int          cycles;
        inst_addr      = '0;
        inst_cacheable = 1'b0;
        inst_valid     = 1'b0;
        flush_valid    = 1'b0;
        exp_data       = '0;
        exp_error      = 1'b0;
        exp_base       = '0;
        bus_allowed    = 1'b0;
        clear_model();

        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > RESET_TIMEOUT) begin
                report_failure("Reset was never released");
            end
        end while (reset);
        assert (!inst_ready && !flush_ready && !wb_m2s.cyc && !wb_m2s.stb)
            else report_failure("Outputs are not idle after reset");

        // Miss on a fresh line, then every word of it hits
        run_fetch(32'h0000_1040, 1'b1);
        for (int w = 0; w < LINE_WORDS; w++) begin
            run_fetch(32'h0000_1040 + 32'(w * 4), 1'b1);
        end

        // Uncached reads never fill, so the cacheable fetch still refills
        run_fetch(32'h0000_2084, 1'b0);
        run_fetch(32'h0000_2084, 1'b0);
        run_fetch(32'h0000_2084, 1'b1);

        run_fetch(ERROR_BASE | 32'h0000_0200, 1'b1);
        run_fetch(ERROR_BASE | 32'h0000_0200, 1'b1);
        run_fetch(ERROR_BASE | 32'h0000_0208, 1'b0);

        flush_cache();
        run_fetch(32'h0000_1048, 1'b1);

        // Same index, different tag
        a.raw = 32'h0000_3050;
        b     = a;
        b.fields.tag = a.fields.tag + 1'b1;
        repeat (3) begin
            run_fetch(a.raw, 1'b1);
            run_fetch(b.raw, 1'b1);
        end

        // Four tags per index in a small window, some in the error region
        rnd = SEED;
        repeat (RANDOM_FETCHES) begin
            rnd   = next_rand(rnd);
            a.raw = 32'h0000_4000 | (rnd & 32'h0000_03fc);
            if (rnd[26:24] == 3'd0) begin
                a.raw = a.raw | ERROR_BASE;
            end
            if (rnd[31:28] == 4'd0) begin
                flush_cache();
            end
            run_fetch(a.raw, rnd[20]);
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
icache_cfg_pkg.sv
icache_bus_pkg.sv
icache_lookup.sv
icache_bypass.sv
icache_refill.sv
icache_top.sv
tb_clock_gen.sv
tb_icache_mem.sv
tb_icache.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_icache
FILELIST  = sources.f
LOG       = sim.log
PASS_MSG  = Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
